/* filelist.f */
hdl/mem_req_pkg.sv
hdl/access_split.sv
hdl/write_align.sv
hdl/read_align.sv
hdl/access_ctrl.sv
hdl/mem_req_ctrl.sv
testbench/tb_bank_model.sv
testbench/tb_mem_req_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# build the memory request controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f filelist.f \
	--top-module tb_mem_req_ctrl \
	-o sim_mem_req_ctrl

./obj_dir/sim_mem_req_ctrl

/* testbench/tb_mem_req_ctrl.sv */
// --------------------------------------------------------------------
// memory request controller testbench
// directed tests against a byte array reference memory
// --------------------------------------------------------------------
`timescale 1ns/1ps

module tb_mem_req_ctrl;
	import mem_req_pkg::*;

	localparam int          TIMEOUT_CYCLES = 8000;
	localparam logic [31:0] SEED           = 32'h0185_e6b9;
	localparam int          MEM_BYTES      = 1 << ADDR_W;

	logic                      clk;
	logic                      rst_n;
	rd_req_t                   rd_req;
	wr_req_t                   wr_req;
	rd_rsp_t                   rd_rsp;
	logic                      wr_ack;
	bank_cmd_t [NUM_BANKS-1:0] bank_cmd;
	logic [NUM_BANKS-1:0]      bank_gnt;
	line_t [NUM_BANKS-1:0]     bank_rdata;

	logic [31:0] stim_state;
	// the grant delays run on a stream of their own
	logic [31:0] gnt_state = ~SEED;
	int          cycle_count = 0;
	logic [7:0]  ref_mem [MEM_BYTES];

	// snapshot of the bank commands in the first cycle any request is up
	logic                      issue_seen;
	logic [NUM_BANKS-1:0]      issue_reqs;
	bank_cmd_t [NUM_BANKS-1:0] issue_cmd;

	mem_req_ctrl dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_req     (rd_req),
		.wr_req     (wr_req),
		.rd_rsp     (rd_rsp),
		.wr_ack     (wr_ack),
		.bank_cmd   (bank_cmd),
		.bank_gnt   (bank_gnt),
		.bank_rdata (bank_rdata)
	);

	tb_bank_model banks0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.rnd        (gnt_state),
		.bank_cmd   (bank_cmd),
		.bank_gnt   (bank_gnt),
		.bank_rdata (bank_rdata)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(negedge clk) gnt_state <= lcg_step(gnt_state);

	// --------------------------------------------------------------------
	// helpers
	// --------------------------------------------------------------------
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] rand_word();
		stim_state = lcg_step(stim_state);
		return stim_state;
	endfunction

	function automatic line_t rand_line();
		line_t d;
		for (int w = 0; w < LINE_W / 32; w++) begin
			d[32*w +: 32] = rand_word();
		end
		return d;
	endfunction

	task automatic report_mismatch(input string test, input line_t exp, input line_t act);
		$display("[ERROR] %s: expected %h, actual %h", test, exp, act);
		$display("Test FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_failure(input string text);
		$display("[ERROR] %s", text);
		$display("Test FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// the address space wraps at 2^19 bytes like the line address does at 2^14
	task automatic ref_write(input addr_t addr, input size_t size, input line_t data);
		for (int i = 0; i < int'(size); i++) begin
			ref_mem[addr_t'(addr + addr_t'(i))] = data[8*i +: 8];
		end
	endtask

	// requested bytes from byte 0 up, zero at and above the size
	function automatic line_t ref_read(input addr_t addr, input size_t size);
		line_t d;
		d = '0;
		for (int i = 0; i < int'(size); i++) begin
			d[8*i +: 8] = ref_mem[addr_t'(addr + addr_t'(i))];
		end
		return d;
	endfunction

	task automatic note_issue();
		logic [NUM_BANKS-1:0] reqs;
		for (int b = 0; b < NUM_BANKS; b++) begin
			reqs[b] = bank_cmd[b].req;
		end
		if (!issue_seen && reqs != '0) begin
			issue_seen = 1'b1;
			issue_reqs = reqs;
			issue_cmd  = bank_cmd;
		end
	endtask

	// outputs are sampled on the falling edge, where they are stable
	task automatic do_write(input addr_t addr, input size_t size, input line_t data);
		issue_seen = 1'b0;
		@(negedge clk);
		wr_req = '{req: 1'b1, addr: addr, size: size, data: data};
		do begin
			@(negedge clk);
			note_issue();
		end while (!wr_ack);
		wr_req.req = 1'b0;
		ref_write(addr, size, data);
	endtask

	task automatic do_read(input addr_t addr, input size_t size, output line_t got);
		issue_seen = 1'b0;
		@(negedge clk);
		rd_req = '{req: 1'b1, addr: addr, size: size};
		do begin
			@(negedge clk);
			note_issue();
		end while (!rd_rsp.valid);
		got        = rd_rsp.data;
		rd_req.req = 1'b0;
	endtask

	task automatic check_read(input string test, input addr_t addr, input size_t size);
		line_t exp;
		line_t got;
		exp = ref_read(addr, size);
		do_read(addr, size, got);
		assert (got == exp) else report_mismatch(test, exp, got);
	endtask

	// --------------------------------------------------------------------
	// tests
	// --------------------------------------------------------------------
	task automatic test_reset_and_aligned();
		logic [NUM_BANKS-1:0] reqs;
		logic [31:0]          r;
		addr_t                addr;
		line_t                data;
		line_t                got;
		for (int b = 0; b < NUM_BANKS; b++) begin
			reqs[b] = bank_cmd[b].req;
		end
		assert (reqs == '0) else report_mismatch("reset_state", '0, line_t'(reqs));
		// wr_ack sits above rd_rsp.valid in the reported value
		assert (!wr_ack && !rd_rsp.valid)
			else report_mismatch("reset_state", '0, line_t'({wr_ack, rd_rsp.valid}));
		r    = rand_word();
		addr = {r[18:5], 5'b0};
		data = rand_line();
		do_write(addr, size_t'(32), data);
		do_read(addr, size_t'(32), got);
		assert (got == data) else report_mismatch("aligned_rw", data, got);
	endtask

	// offset 28 and 12 bytes: line 0x050 in bank 0 and line 0x051 in bank 1, both row 0x28
	task automatic test_split_write();
		addr_t addr;
		line_t data;
		addr = 19'h0_0a1c;
		do_write(19'h0_0a00, size_t'(32), rand_line());
		do_write(19'h0_0a20, size_t'(32), rand_line());
		data = rand_line();
		do_write(addr, size_t'(12), data);
		assert (issue_reqs == 16'h0003)
			else report_mismatch("split_write", line_t'(16'h0003), line_t'(issue_reqs));
		assert (issue_cmd[0].row == 10'h028)
			else report_mismatch("split_write", line_t'(10'h028), line_t'(issue_cmd[0].row));
		assert (issue_cmd[1].row == 10'h028)
			else report_mismatch("split_write", line_t'(10'h028), line_t'(issue_cmd[1].row));
		check_read("split_write", addr, size_t'(12));
		// the neighbours in both lines keep the background bytes
		check_read("split_write", 19'h0_0a00, size_t'(32));
		check_read("split_write", 19'h0_0a20, size_t'(32));
	endtask

	task automatic test_read_first();
		addr_t addr;
		line_t old_data;
		line_t new_data;
		line_t got;
		logic  rd_seen;
		addr = 19'h4_1230;
		do_write(addr, size_t'(16), rand_line());
		old_data = ref_read(addr, size_t'(16));
		new_data = rand_line();
		@(negedge clk);
		rd_req  = '{req: 1'b1, addr: addr, size: size_t'(16)};
		wr_req  = '{req: 1'b1, addr: addr, size: size_t'(16), data: new_data};
		rd_seen = 1'b0;
		got     = '0;
		do begin
			@(negedge clk);
			assert (rd_seen || !wr_ack)
				else report_failure("read_first: write acknowledged before the read");
			if (rd_rsp.valid) begin
				rd_seen    = 1'b1;
				got        = rd_rsp.data;
				rd_req.req = 1'b0;
			end
		end while (!wr_ack);
		wr_req.req = 1'b0;
		assert (got == old_data) else report_mismatch("read_first", old_data, got);
		ref_write(addr, size_t'(16), new_data);
		check_read("read_first", addr, size_t'(16));
	endtask

	// last line of region 2 sits in bank 5 row 0x3ff, its next line is bank 6 row 0
	task automatic test_region_edge();
		addr_t addr;
		addr = {3'd2, 11'h7ff, 5'd20};
		do_write(addr, size_t'(24), rand_line());
		assert (issue_reqs == 16'h0060)
			else report_mismatch("region_edge", line_t'(16'h0060), line_t'(issue_reqs));
		assert (issue_cmd[5].row == 10'h3ff)
			else report_mismatch("region_edge", line_t'(10'h3ff), line_t'(issue_cmd[5].row));
		assert (issue_cmd[6].row == 10'h000)
			else report_mismatch("region_edge", '0, line_t'(issue_cmd[6].row));
		check_read("region_edge", addr, size_t'(24));
		check_read("region_edge", {3'd3, 16'h0000}, size_t'(32));
	endtask

	// a 256 byte window at the top of a random region so accesses overlap and cross regions
	task automatic test_random_rw();
		logic [31:0] r;
		addr_t       addr;
		size_t       size;
		for (int n = 0; n < 200; n++) begin
			r    = rand_word();
			addr = addr_t'({r[31:29], 16'hff80} + {11'b0, r[7:0]});
			size = size_t'(r[12:8]) + size_t'(1);
			if (r[16]) begin
				do_write(addr, size, rand_line());
			end else begin
				check_read("random_rw", addr, size);
			end
		end
	endtask

	// --------------------------------------------------------------------
	// timeout and main sequence
	// --------------------------------------------------------------------
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			report_failure("timeout: the DUT stopped answering");
		end
	end

	initial begin
		rst_n      = 1'b0;
		rd_req     = '0;
		wr_req     = '0;
		stim_state = SEED;
		issue_seen = 1'b0;
		issue_reqs = '0;
		issue_cmd  = '0;
		for (int i = 0; i < MEM_BYTES; i++) begin
			ref_mem[i] = 8'h00;
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		test_reset_and_aligned();
		test_split_write();
		test_read_first();
		test_region_edge();
		test_random_rw();
		$display("Test OK");
		$finish;
	end

endmodule

/* testbench/tb_bank_model.sv */
// --------------------------------------------------------------------
// bank model
// 16 bank SRAM with random grant delays and one cycle read latency
// --------------------------------------------------------------------
`timescale 1ns/1ps

module tb_bank_model (
	input  logic                                                 clk,
	input  logic                                                 rst_n,
	input  logic [31:0]                                          rnd,
	input  mem_req_pkg::bank_cmd_t [mem_req_pkg::NUM_BANKS-1:0] bank_cmd,
	output logic [mem_req_pkg::NUM_BANKS-1:0]                    bank_gnt,
	output mem_req_pkg::line_t [mem_req_pkg::NUM_BANKS-1:0]     bank_rdata
);
	import mem_req_pkg::*;

	localparam int ROWS = 1 << ROW_W;

	line_t                mem [NUM_BANKS][ROWS];
	// armed is set while a request waits out its delay
	logic [NUM_BANKS-1:0] armed;
	logic [1:0]           wait_cnt [NUM_BANKS];
	logic [1:0]           left [NUM_BANKS];

	initial begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			for (int r = 0; r < ROWS; r++) begin
				mem[b][r] = '0;
			end
		end
	end

	// a fresh request draws its delay of 0 to 3 cycles from two bits of rnd
	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			left[b]     = armed[b] ? wait_cnt[b] : rnd[2*b +: 2];
			bank_gnt[b] = bank_cmd[b].req && (left[b] == 2'd0);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			armed      <= '0;
			bank_rdata <= '0;
			for (int b = 0; b < NUM_BANKS; b++) begin
				wait_cnt[b] <= 2'd0;
			end
		end else begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				armed[b] <= bank_cmd[b].req && !bank_gnt[b];
				if (bank_cmd[b].req && !bank_gnt[b]) begin
					wait_cnt[b] <= left[b] - 2'd1;
				end
				// the line shows up on bank_rdata in the cycle after the grant
				if (bank_gnt[b] && !bank_cmd[b].we) begin
					bank_rdata[b] <= mem[b][bank_cmd[b].row];
				end
			end
		end
	end

	// writes land at the grant, only the enabled bytes change
	always @(posedge clk) begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (bank_gnt[b] && bank_cmd[b].we) begin
				for (int k = 0; k < LINE_BYTES; k++) begin
					if (bank_cmd[b].bmask[k]) begin
						mem[b][bank_cmd[b].row][8*k +: 8] <= bank_cmd[b].wdata[8*k +: 8];
					end
				end
			end
		end
	end

endmodule

/* hdl/mem_req_ctrl.sv */
// --------------------------------------------------------------------
// memory request controller
// single client front end for a 16 bank SRAM with line split accesses
// --------------------------------------------------------------------
`timescale 1ns/1ps

module mem_req_ctrl (
	input  logic                                                 clk,
	input  logic                                                 rst_n,
	input  mem_req_pkg::rd_req_t                                 rd_req,
	input  mem_req_pkg::wr_req_t                                 wr_req,
	output mem_req_pkg::rd_rsp_t                                 rd_rsp,
	output logic                                                 wr_ack,
	output mem_req_pkg::bank_cmd_t [mem_req_pkg::NUM_BANKS-1:0] bank_cmd,
	input  logic [mem_req_pkg::NUM_BANKS-1:0]                    bank_gnt,
	input  mem_req_pkg::line_t [mem_req_pkg::NUM_BANKS-1:0]     bank_rdata
);
	import mem_req_pkg::*;

	split_t split;
	logic   is_write;
	line_t  cap_wdata;
	logic   first_pend;
	logic   second_pend;
	logic   capture_first;
	logic   capture_second;
	logic   rd_valid;
	line_t  first_data;
	line_t  second_data;
	bmask_t first_mask;
	bmask_t second_mask;
	line_t  rdata;

	// reads send no byte enables, nothing gets written
	function automatic bank_cmd_t make_cmd(input logic we, input row_t row,
		input line_t wdata, input bmask_t bmask);
		bank_cmd_t cmd;
		cmd.req   = 1'b1;
		cmd.we    = we;
		cmd.row   = row;
		cmd.wdata = wdata;
		cmd.bmask = we ? bmask : '0;
		return cmd;
	endfunction

	access_ctrl ctrl0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.rd_req         (rd_req),
		.wr_req         (wr_req),
		.bank_gnt       (bank_gnt),
		.split          (split),
		.is_write       (is_write),
		.cap_wdata      (cap_wdata),
		.first_pend     (first_pend),
		.second_pend    (second_pend),
		.capture_first  (capture_first),
		.capture_second (capture_second),
		.wr_ack         (wr_ack),
		.rd_valid       (rd_valid)
	);

	write_align walign0 (
		.split       (split),
		.wdata       (cap_wdata),
		.first_data  (first_data),
		.second_data (second_data),
		.first_mask  (first_mask),
		.second_mask (second_mask)
	);

	// the two halves always land in different banks, odd and even lines alternate
	always_comb begin
		bank_cmd = '0;
		if (first_pend) begin
			bank_cmd[split.first.bank] = make_cmd(is_write, split.first.row,
				first_data, first_mask);
		end
		if (second_pend) begin
			bank_cmd[split.second.bank] = make_cmd(is_write, split.second.row,
				second_data, second_mask);
		end
	end

	// banks stay fixed during the access so the return lines select directly
	read_align ralign0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.capture_first  (capture_first),
		.capture_second (capture_second),
		.first_line     (bank_rdata[split.first.bank]),
		.second_line    (bank_rdata[split.second.bank]),
		.split          (split),
		.rdata          (rdata)
	);

	assign rd_rsp.valid = rd_valid;
	assign rd_rsp.data  = rdata;

endmodule

/* hdl/access_ctrl.sv */
// --------------------------------------------------------------------
// access control
// captures one request at a time, drives bank requests, pulses responses
// --------------------------------------------------------------------
`timescale 1ns/1ps

module access_ctrl (
	input  logic                              clk,
	input  logic                              rst_n,
	input  mem_req_pkg::rd_req_t              rd_req,
	input  mem_req_pkg::wr_req_t              wr_req,
	input  logic [mem_req_pkg::NUM_BANKS-1:0] bank_gnt,
	output mem_req_pkg::split_t               split,
	output logic                              is_write,
	output mem_req_pkg::line_t                cap_wdata,
	output logic                              first_pend,
	output logic                              second_pend,
	output logic                              capture_first,
	output logic                              capture_second,
	output logic                              wr_ack,
	output logic                              rd_valid
);
	import mem_req_pkg::*;

	// ISSUE holds the bank requests, WAIT_DATA covers the read capture cycle
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT_DATA,
		RESP
	} state_t;

	state_t state;
	state_t next_state;

	// captured request, held for the whole access
	addr_t cap_addr;
	size_t cap_size;

	logic accept;
	logic busy;
	// set once a half has seen its grant
	logic first_done;
	logic second_done;
	// grant for a half that is still pending
	logic first_gnt;
	logic second_gnt;
	logic all_granted;

	// --------------------------------------------------------------------
	// request capture
	// --------------------------------------------------------------------
	// a read wins when both are raised, the write simply waits in IDLE
	assign accept = (state == IDLE) && (rd_req.req || wr_req.req);
	assign busy   = (state != IDLE);

	always_ff @(posedge clk) begin
		if (accept) begin
			if (rd_req.req) begin
				cap_addr <= rd_req.addr;
				cap_size <= rd_req.size;
			end else begin
				cap_addr <= wr_req.addr;
				cap_size <= wr_req.size;
			end
			cap_wdata <= wr_req.data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			is_write <= 1'b0;
		end else if (accept) begin
			is_write <= !rd_req.req;
		end
	end

	access_split split0 (
		.addr  (cap_addr),
		.size  (cap_size),
		.valid (busy),
		.split (split)
	);

	// --------------------------------------------------------------------
	// bank request tracking
	// --------------------------------------------------------------------
	// both halves go out together in ISSUE and each drops on its own grant
	assign first_pend  = (state == ISSUE) && !first_done;
	assign second_pend = (state == ISSUE) && split.two_lines && !second_done;

	assign first_gnt  = first_pend && bank_gnt[split.first.bank];
	assign second_gnt = second_pend && bank_gnt[split.second.bank];

	// done once every half needed has been granted, this cycle or before
	assign all_granted = (first_done || first_gnt) &&
		(!split.two_lines || second_done || second_gnt);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			first_done  <= 1'b0;
			second_done <= 1'b0;
		end else if (accept) begin
			first_done  <= 1'b0;
			second_done <= 1'b0;
		end else begin
			if (first_gnt) begin
				first_done <= 1'b1;
			end
			if (second_gnt) begin
				second_done <= 1'b1;
			end
		end
	end

	// the bank drives the read line in the cycle after the grant
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			capture_first  <= 1'b0;
			capture_second <= 1'b0;
		end else begin
			capture_first  <= first_gnt && !is_write;
			capture_second <= second_gnt && !is_write;
		end
	end

	// --------------------------------------------------------------------
	// FSM
	// --------------------------------------------------------------------
	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (accept) begin
					next_state = ISSUE;
				end
			end
			ISSUE: begin
				// a write is done at its last grant, a read still needs the data cycle
				if (all_granted) begin
					next_state = is_write ? RESP : WAIT_DATA;
				end
			end
			WAIT_DATA: begin
				next_state = RESP;
			end
			// the client drops its request while it sees the response
			RESP: begin
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	assign wr_ack   = (state == RESP) && is_write;
	assign rd_valid = (state == RESP) && !is_write;

	// --------------------------------------------------------------------
	// checks
	// --------------------------------------------------------------------
	// a raised half keeps its request until the addressed bank grants it
	a_first_hold: assert property (@(posedge clk) disable iff (!rst_n)
		first_pend && !bank_gnt[split.first.bank] |=> first_pend)
		else $error("access_ctrl: first half dropped before its grant");

	a_second_hold: assert property (@(posedge clk) disable iff (!rst_n)
		second_pend && !bank_gnt[split.second.bank] |=> second_pend)
		else $error("access_ctrl: second half dropped before its grant");

	a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n)
		!(wr_ack && rd_valid))
		else $error("access_ctrl: write ack and read valid in the same cycle");

endmodule

/* hdl/read_align.sv */
// --------------------------------------------------------------------
// read align
// buffers the returned bank lines and realigns the requested bytes
// --------------------------------------------------------------------
`timescale 1ns/1ps

module read_align (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                capture_first,
	input  logic                capture_second,
	input  mem_req_pkg::line_t  first_line,
	input  mem_req_pkg::line_t  second_line,
	input  mem_req_pkg::split_t split,
	output mem_req_pkg::line_t  rdata
);
	import mem_req_pkg::*;

	// two line buffer, lower line from the first bank and upper line from the second
	line_t buf_lo;
	line_t buf_hi;

	logic [2*LINE_W-1:0] shifted;
	logic [OFFS_W+2:0]   shift_bits;
	size_t               total;
	bmask_t              keep;
	line_t               keep_bits;

	// --------------------------------------------------------------------
	// capture
	// --------------------------------------------------------------------
	// each bank holds its line only in the cycle after the grant,
	// so the strobes come from the grants one cycle delayed
	always_ff @(posedge clk) begin
		if (capture_first) begin
			buf_lo <= first_line;
		end
		if (capture_second) begin
			buf_hi <= second_line;
		end
	end

	// --------------------------------------------------------------------
	// realign
	// --------------------------------------------------------------------
	// drop the bytes below the start offset, the second line
	// follows straight on from the end of the first one
	assign shift_bits = {split.first.offset, 3'b000};
	assign shifted    = {buf_hi, buf_lo} >> shift_bits;

	// requested size is the sum of the two halves
	assign total = split.first.count + split.second.count;

	// keep bytes below the size, everything at and above it reads as zero
	assign keep = bmask_t'({LINE_BYTES{1'b1}} >> (size_t'(LINE_BYTES) - total));

	// stretch the byte enables to bit enables
	always_comb begin
		for (int b = 0; b < LINE_BYTES; b++) begin
			keep_bits[b*8 +: 8] = {8{keep[b]}};
		end
	end

	// a stale upper line never leaks out since one line accesses end below 32 bytes
	assign rdata = shifted[LINE_W-1:0] & keep_bits;

	// --------------------------------------------------------------------
	// checks
	// --------------------------------------------------------------------
	// only a line crossing read fetches a second line
	a_second_only_split: assert property (@(posedge clk) disable iff (!rst_n)
		capture_second |-> split.two_lines)
		else $error("read_align: second line captured for a single line access");

endmodule

/* hdl/write_align.sv */
// --------------------------------------------------------------------
// write align
// places the write payload in its lines and builds the byte masks
// --------------------------------------------------------------------
`timescale 1ns/1ps

module write_align (
	input  mem_req_pkg::split_t split,
	input  mem_req_pkg::line_t  wdata,
	output mem_req_pkg::line_t  first_data,
	output mem_req_pkg::line_t  second_data,
	output mem_req_pkg::bmask_t first_mask,
	output mem_req_pkg::bmask_t second_mask
);
	import mem_req_pkg::*;

	// shift amounts in bits, a byte count times 8
	logic [OFFS_W+2:0] first_shift;
	logic [SIZE_W+2:0] second_shift;
	// contiguous byte enables from byte 0, one per half
	bmask_t first_run;
	bmask_t second_run;

	assign first_shift  = {split.first.offset, 3'b000};
	assign second_shift = {split.first.count, 3'b000};

	// the first half moves up to its offset inside the line
	assign first_data = wdata << first_shift;

	// the second half takes what did not fit in the first line,
	// a count of 32 shifts everything out which is fine for a single line access
	assign second_data = wdata >> second_shift;

	// count ones from the bottom, a count of 0 leaves the run empty
	assign first_run  = bmask_t'({LINE_BYTES{1'b1}} >> (size_t'(LINE_BYTES) - split.first.count));
	assign second_run = bmask_t'({LINE_BYTES{1'b1}} >> (size_t'(LINE_BYTES) - split.second.count));

	// first line enables offset .. offset + count - 1
	assign first_mask = first_run << split.first.offset;

	// second line enables bytes 0 .. second count - 1
	// a one line access has a second count of 0 and enables nothing there
	assign second_mask = second_run;

endmodule

/* hdl/access_split.sv */
// --------------------------------------------------------------------
// access split
// decodes a captured request into one or two line accesses
// --------------------------------------------------------------------
`timescale 1ns/1ps

module access_split (
	input  mem_req_pkg::addr_t  addr,
	input  mem_req_pkg::size_t  size,
	input  logic                valid,
	output mem_req_pkg::split_t split
);
	import mem_req_pkg::*;

	line_addr_t first_line;
	line_addr_t second_line;
	offs_t      offset;
	size_t      room;
	size_t      first_count;
	logic       two_lines;

	// bank is the region (top three line address bits) plus the odd/even line bit
	function automatic bank_t line_bank(input line_addr_t line);
		return {line[LINE_ADDR_W-1:ROW_W+1], line[0]};
	endfunction

	// the row sits between the region bits and the odd/even bit
	function automatic row_t line_row(input line_addr_t line);
		return line[ROW_W:1];
	endfunction

	assign offset     = addr[OFFS_W-1:0];
	assign first_line = addr[ADDR_W-1:OFFS_W];
	// the next line wraps at the top of the address space,
	// the last odd line of a region carries into the even bank of the next one
	assign second_line = first_line + 1'b1;

	// bytes left in the first line from the offset up
	assign room        = size_t'(LINE_BYTES) - size_t'(offset);
	assign two_lines   = size > room;
	assign first_count = two_lines ? room : size;

	always_comb begin
		split.two_lines     = two_lines;
		split.first.bank    = line_bank(first_line);
		split.first.row     = line_row(first_line);
		split.first.offset  = offset;
		split.first.count   = first_count;
		// the second half always starts at byte 0 of its line
		split.second.bank   = line_bank(second_line);
		split.second.row    = line_row(second_line);
		split.second.offset = '0;
		split.second.count  = size - first_count;
	end

	// a live request never asks for an empty or oversized access
	always_comb begin
		if (valid) begin
			a_size_range: assert final (size >= size_t'(1) && size <= size_t'(LINE_BYTES))
				else $error("access_split: size %0d outside 1..%0d", size, LINE_BYTES);
		end
	end

endmodule

/* hdl/mem_req_pkg.sv */
// --------------------------------------------------------------------
// memory request controller package
// sizes, field types and the request, response and bank command structs
// --------------------------------------------------------------------
package mem_req_pkg;

	// --------------------------------------------------------------------
	// sizes
	// --------------------------------------------------------------------
	// one bank line is 32 bytes wide
	localparam int LINE_BYTES  = 32;
	localparam int LINE_W      = 256;
	// byte address covers 8 regions of 64 KB
	localparam int ADDR_W      = 19;
	// a byte count has to hold the value 32
	localparam int SIZE_W      = 6;
	localparam int NUM_BANKS   = 16;
	localparam int BANK_W      = 4;
	// row inside a bank comes from address bits 15..6
	localparam int ROW_W       = 10;
	// byte address without the offset bits
	localparam int LINE_ADDR_W = 14;
	// byte offset inside a line
	localparam int OFFS_W      = 5;

	// --------------------------------------------------------------------
	// field types
	// --------------------------------------------------------------------
	typedef logic [ADDR_W-1:0]      addr_t;
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;
	typedef logic [SIZE_W-1:0]      size_t;
	typedef logic [LINE_W-1:0]      line_t;
	typedef logic [LINE_BYTES-1:0]  bmask_t;
	typedef logic [BANK_W-1:0]      bank_t;
	typedef logic [ROW_W-1:0]       row_t;
	typedef logic [OFFS_W-1:0]      offs_t;

	// --------------------------------------------------------------------
	// client side
	// --------------------------------------------------------------------
	// req is a level held until the matching response shows up
	typedef struct packed {
		logic  req;
		addr_t addr;
		size_t size;
	} rd_req_t;

	// the write payload sits in the low bytes of data
	typedef struct packed {
		logic  req;
		addr_t addr;
		size_t size;
		line_t data;
	} wr_req_t;

	// valid is a one cycle pulse, data holds the bytes from byte 0 up
	typedef struct packed {
		logic  valid;
		line_t data;
	} rd_rsp_t;

	// --------------------------------------------------------------------
	// bank side
	// --------------------------------------------------------------------
	// one line access: where it goes and which bytes of the line it touches
	typedef struct packed {
		bank_t bank;
		row_t  row;
		offs_t offset;
		size_t count;
	} line_acc_t;

	// a request split into up to two line accesses
	typedef struct packed {
		line_acc_t first;
		line_acc_t second;
		logic      two_lines;
	} split_t;

	// req stays high until the bank grants, bmask has one bit per byte
	typedef struct packed {
		logic   req;
		logic   we;
		row_t   row;
		line_t  wdata;
		bmask_t bmask;
	} bank_cmd_t;

endpackage
